//--- Bender.yml
package:
  name: music_box

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/musicBoxPkg.sv
      - source/inputSmoother.sv
      - source/toneSynth.sv
      - source/sampleFifo.sv
      - source/dacSerializer.sv
      - source/musicBoxTop.sv

  - target: test
    include_dirs:
      - source
    files:
      - verif/musicBoxTb.sv

//--- source/dacSerializer.sv
/*
 * DAC serializer, the sample consumer
 * Pops levels, scales them to 12-bit DAC codes, shifts out 16-bit SPI frames
 */

`timescale 1ns/1ns
`default_nettype none

`include "musicBox_cfg.svh"

module dacSerializer (
	input  logic               clock50Mhz,
	input  logic               arstN,
	input  logic               empty,
	input  musicBoxPkg::levelT headLevel,
	output logic               pop,
	output logic               spiSclk,
	output logic               spiSyncN, // Low for the whole frame
	output logic               spiDin
);

	localparam int HalfW = $clog2(`MB_SCLK_HALF + 1);

	musicBoxPkg::serStateT state;
	musicBoxPkg::dacCodeT  dacCode;
	musicBoxPkg::spiWordT  shiftWord;
	logic [HalfW-1:0]      halfCnt;
	logic [3:0]            bitCnt;
	logic                  halfDone;

	assign pop      = (state == musicBoxPkg::idle) && !empty;
	assign dacCode  = {headLevel, 4'h0}; // 256 * 16 fills 12 bits
	assign halfDone = (halfCnt == HalfW'(`MB_SCLK_HALF - 1));

	// Word captured with the pop, shifted on each SCLK rise
	always_ff @(posedge clock50Mhz) begin
		if (pop)
			shiftWord <= {4'b0000, dacCode};
		else if (state == musicBoxPkg::shift && halfDone && !spiSclk)
			shiftWord <= {shiftWord[14:0], 1'b0};
	end

	// ----------------------------------------
	// Frame FSM
	// ----------------------------------------
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			state    <= musicBoxPkg::idle;
			halfCnt  <= '0;
			bitCnt   <= '0;
			spiSclk  <= 1'b0;
			spiSyncN <= 1'b1;
			spiDin   <= 1'b0;
		end else begin
			case (state)
				musicBoxPkg::idle: begin
					if (pop)
						state <= musicBoxPkg::load;
				end
				musicBoxPkg::load: begin
					spiSyncN <= 1'b0; // Frame start
					halfCnt  <= '0;
					bitCnt   <= '0;
					state    <= musicBoxPkg::shift;
				end
				musicBoxPkg::shift: begin
					if (!halfDone) begin
						halfCnt <= halfCnt + 1'b1;
					end else begin
						halfCnt <= '0;
						spiSclk <= !spiSclk;
						if (!spiSclk) begin
							spiDin <= shiftWord[15]; // MSB first, DAC samples on fall
						end else begin
							bitCnt <= bitCnt + 1'b1;
							if (bitCnt == 4'd15)
								state <= musicBoxPkg::gap; // 16th fall
						end
					end
				end
				default: begin // gap
					spiSyncN <= 1'b1;
					spiDin   <= 1'b0;
					state    <= musicBoxPkg::idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/inputSmoother.sv
/*
 * Button input smoother
 * Synchronizes one active-low button and filters switch bounce
 */

`timescale 1ns/1ns
`default_nettype none

`include "musicBox_cfg.svh"

module inputSmoother (
	input  logic clock50Mhz,
	input  logic arstN,
	input  logic rawN,    // Asynchronous button, low when pressed
	output logic smoothN  // Debounced, high when released
);

	localparam int CntW = $clog2(`MB_DEBOUNCE_CYCLES + 1);

	logic            syncMeta;
	logic            syncQ;
	logic [CntW-1:0] stableCnt; // Cycles the new value has held

	// Two-flop synchronizer
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			syncMeta <= 1'b1;
			syncQ    <= 1'b1;
		end else begin
			syncMeta <= rawN;
			syncQ    <= syncMeta;
		end
	end

	// Output moves only after a full stable run
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			stableCnt <= '0;
			smoothN   <= 1'b1; // Released
		end else if (syncQ == smoothN) begin
			stableCnt <= '0; // Bounce back, start over
		end else if (stableCnt == CntW'(`MB_DEBOUNCE_CYCLES - 1)) begin
			stableCnt <= '0;
			smoothN   <= syncQ;
		end else begin
			stableCnt <= stableCnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/musicBoxPkg.sv
/*
 * Music box shared types
 * Audio, DAC and SPI word types, serializer states, volume scaling
 */

`default_nettype none

package musicBoxPkg;

	typedef logic [7:0]  levelT;    // Audio level, 0 is rest
	typedef logic [11:0] dacCodeT;  // Level times 16
	typedef logic [15:0] spiWordT;  // 4 control bits then DAC code
	typedef logic [5:0]  keyMaskT;  // One bit per music key
	typedef logic [2:0]  keyIndexT;
	typedef logic [5:0]  phaseT;    // Sample count within tone period

	// DAC serializer FSM
	typedef enum logic [1:0] {
		idle,
		load,
		shift,
		gap
	} serStateT;

	// Level times gain over 255, rounded
	function automatic levelT scaleLevel(input levelT level, input levelT gain);
		logic [15:0] prod; // 255*255+127 still fits
		prod = 16'(level) * 16'(gain) + 16'd127;
		return levelT'(prod / 16'd255);
	endfunction

endpackage

`default_nettype wire

//--- source/musicBoxTop.sv
/*
 * Music box top level
 * Tone producer, sample FIFO and SPI DAC serializer
 */

`timescale 1ns/1ns
`default_nettype none

module musicBoxTop (
	input  logic                 clock50Mhz,
	input  logic                 arstN,
	input  musicBoxPkg::keyMaskT musicKeysN,
	input  logic                 beeModeN,
	input  musicBoxPkg::levelT   volume,
	output logic                 spiSclk,
	output logic                 spiSyncN,
	output logic                 spiDin,
	output logic                 beeModeLed
);

	logic               sampleValid;
	musicBoxPkg::levelT sample;
	musicBoxPkg::levelT headLevel;
	logic               fifoEmpty;
	logic               fifoPop;

	// ----------------------------------------
	// Producer
	// ----------------------------------------
	toneSynth toneSynth_i (
		.clock50Mhz  (clock50Mhz),
		.arstN       (arstN),
		.musicKeysN  (musicKeysN),
		.beeModeN    (beeModeN),
		.volume      (volume),
		.sampleValid (sampleValid),
		.sample      (sample),
		.beeMode     (beeModeLed) // LED shows bee mode
	);

	sampleFifo sampleFifo_i (
		.clock50Mhz (clock50Mhz),
		.arstN      (arstN),
		.push       (sampleValid),
		.pushLevel  (sample),
		.pop        (fifoPop),
		.headLevel  (headLevel),
		.empty      (fifoEmpty),
		.full       () // Never reached at this sample rate
	);

	// ----------------------------------------
	// Consumer
	// ----------------------------------------
	dacSerializer dacSerializer_i (
		.clock50Mhz (clock50Mhz),
		.arstN      (arstN),
		.empty      (fifoEmpty),
		.headLevel  (headLevel),
		.pop        (fifoPop),
		.spiSclk    (spiSclk),
		.spiSyncN   (spiSyncN),
		.spiDin     (spiDin)
	);

endmodule

`default_nettype wire

//--- source/musicBox_cfg.svh
/*
 * Music box configuration
 * Divider counts, debounce length, FIFO depth and key tone periods
 */

`ifndef MUSICBOX_CFG_SVH
`define MUSICBOX_CFG_SVH

// ----------------------------------------
// Timing
// ----------------------------------------
// Clocks per audio sample, 2267 gives 22.05 kHz on the 50 MHz board
`define MB_SAMPLE_DIV 200
`define MB_SCLK_HALF 2 // Clocks per SCLK level

// Stable cycles before a button output follows
`define MB_DEBOUNCE_CYCLES 16

// Sample FIFO entries, power of two
`define MB_FIFO_DEPTH 8

// ----------------------------------------
// Key tone periods
// ----------------------------------------
// Counted in samples, even, 4 to 32
`define MB_KEY_PERIOD0 32
`define MB_KEY_PERIOD1 28
`define MB_KEY_PERIOD2 24
`define MB_KEY_PERIOD3 20
`define MB_KEY_PERIOD4 16
`define MB_KEY_PERIOD5 12 // Highest note

`endif

//--- source/sampleFifo.sv
/*
 * Sample FIFO
 * Circular buffer of audio levels between tone producer and DAC consumer
 */

`timescale 1ns/1ns
`default_nettype none

`include "musicBox_cfg.svh"

module sampleFifo (
	input  logic               clock50Mhz,
	input  logic               arstN,
	input  logic               push,      // Strobe, dropped when full
	input  musicBoxPkg::levelT pushLevel,
	input  logic               pop,       // Strobe, ignored when empty
	output musicBoxPkg::levelT headLevel,
	output logic               empty,
	output logic               full
);

	localparam int PtrW = $clog2(`MB_FIFO_DEPTH);
	localparam int CntW = $clog2(`MB_FIFO_DEPTH + 1);

	musicBoxPkg::levelT mem [`MB_FIFO_DEPTH];
	logic [PtrW-1:0]    wrPtr;
	logic [PtrW-1:0]    rdPtr;
	logic [CntW-1:0]    count;
	logic               doPush;
	logic               doPop;

	assign doPush    = push && !full;
	assign doPop     = pop && !empty;
	assign empty     = (count == '0);
	assign full      = (count == CntW'(`MB_FIFO_DEPTH));
	assign headLevel = mem[rdPtr]; // Oldest entry

	always_ff @(posedge clock50Mhz) begin
		if (doPush)
			mem[wrPtr] <= pushLevel;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // None or both
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/toneSynth.sv
/*
 * Tone synthesizer, the sample producer
 * Smooths keys and bee button, picks the lowest pressed key and emits
 * one volume-scaled square or sawtooth level per sample strobe
 */

`timescale 1ns/1ns
`default_nettype none

`include "musicBox_cfg.svh"

module toneSynth (
	input  logic                  clock50Mhz,
	input  logic                  arstN,
	input  musicBoxPkg::keyMaskT  musicKeysN, // Active low keys
	input  logic                  beeModeN,   // Active low bee button
	input  musicBoxPkg::levelT    volume,
	output logic                  sampleValid, // One cycle per sample
	output musicBoxPkg::levelT    sample,
	output logic                  beeMode
);

	localparam int DivW = $clog2(`MB_SAMPLE_DIV);

	musicBoxPkg::keyMaskT  keysSmoothN;
	musicBoxPkg::keyIndexT keyIdx;
	musicBoxPkg::keyIndexT lastKey;
	musicBoxPkg::phaseT    phase;
	musicBoxPkg::phaseT    effPhase;
	musicBoxPkg::phaseT    period;
	musicBoxPkg::levelT    sawStep;
	musicBoxPkg::levelT    rawLevel;
	logic [13:0]           sawProd;
	logic [DivW-1:0]       divCnt;
	logic                  sampleTick;
	logic                  anyKey;
	logic                  lastAny;
	logic                  lastBee;
	logic                  restart;
	logic                  beeSmoothN;
	logic                  beePrevN;

	// ----------------------------------------
	// Input smoothing
	// ----------------------------------------
	for (genvar k = 0; k < 6; k++) begin : genKeySmooth
		inputSmoother keySmooth_i (
			.clock50Mhz (clock50Mhz),
			.arstN      (arstN),
			.rawN       (musicKeysN[k]),
			.smoothN    (keysSmoothN[k])
		);
	end

	inputSmoother beeSmooth_i (
		.clock50Mhz (clock50Mhz),
		.arstN      (arstN),
		.rawN       (beeModeN),
		.smoothN    (beeSmoothN)
	);

	// Lowest-numbered pressed key wins
	always_comb begin
		keyIdx = '0;
		anyKey = 1'b0;
		for (int i = 5; i >= 0; i--) begin
			if (!keysSmoothN[i]) begin
				keyIdx = musicBoxPkg::keyIndexT'(i);
				anyKey = 1'b1;
			end
		end
	end

	// Period and sawtooth step per key
	always_comb begin
		case (keyIdx)
			3'd0:    period = `MB_KEY_PERIOD0;
			3'd1:    period = `MB_KEY_PERIOD1;
			3'd2:    period = `MB_KEY_PERIOD2;
			3'd3:    period = `MB_KEY_PERIOD3;
			3'd4:    period = `MB_KEY_PERIOD4;
			default: period = `MB_KEY_PERIOD5;
		endcase
		case (keyIdx)
			3'd0:    sawStep = 255 / (`MB_KEY_PERIOD0 - 1);
			3'd1:    sawStep = 255 / (`MB_KEY_PERIOD1 - 1);
			3'd2:    sawStep = 255 / (`MB_KEY_PERIOD2 - 1);
			3'd3:    sawStep = 255 / (`MB_KEY_PERIOD3 - 1);
			3'd4:    sawStep = 255 / (`MB_KEY_PERIOD4 - 1);
			default: sawStep = 255 / (`MB_KEY_PERIOD5 - 1);
		endcase
	end

	// ----------------------------------------
	// Waveform
	// ----------------------------------------
	assign sampleTick = (divCnt == DivW'(`MB_SAMPLE_DIV - 1));
	assign restart    = (keyIdx != lastKey) || (anyKey != lastAny) || (beeMode != lastBee);
	assign effPhase   = restart ? '0 : phase; // New key or mode starts at 0
	assign sawProd    = 14'(effPhase) * 14'(sawStep);

	always_comb begin
		if (!anyKey)
			rawLevel = '0; // Rest
		else if (beeMode)
			rawLevel = musicBoxPkg::levelT'(sawProd);
		else
			rawLevel = (effPhase < (period >> 1)) ? 8'd255 : 8'd0;
	end

	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			divCnt      <= '0;
			sampleValid <= 1'b0;
			phase       <= '0;
			lastKey     <= '0;
			lastAny     <= 1'b0;
			lastBee     <= 1'b0;
			beeMode     <= 1'b0;
			beePrevN    <= 1'b1;
		end else begin
			divCnt      <= sampleTick ? '0 : divCnt + 1'b1;
			sampleValid <= sampleTick;
			beePrevN    <= beeSmoothN;
			if (beePrevN && !beeSmoothN)
				beeMode <= !beeMode; // Toggle on press
			if (sampleTick) begin
				phase   <= (effPhase == period - 1'b1) ? '0 : effPhase + 1'b1;
				lastKey <= keyIdx;
				lastAny <= anyKey;
				lastBee <= beeMode;
			end
		end
	end

	// Scaled level, valid with the strobe
	always_ff @(posedge clock50Mhz) begin
		if (sampleTick)
			sample <= musicBoxPkg::scaleLevel(rawLevel, volume);
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/musicBoxPkg.sv
source/inputSmoother.sv
source/toneSynth.sv
source/sampleFifo.sv
source/dacSerializer.sv
source/musicBoxTop.sv
verif/musicBoxTb.sv

//--- verif/musicBoxTb.sv
/*
 * Music box testbench
 * Random keys, bee presses and volume, SPI frame capture and a tone model
 */

`timescale 1ns/1ns
`default_nettype none

`include "musicBox_cfg.svh"

module musicBoxTb;

	localparam int NumPhases    = 8;
	localparam int MaxPeriod    = 32; // Longest tone period the config allows
	localparam int SettleCycles = `MB_DEBOUNCE_CYCLES + 3 * `MB_SAMPLE_DIV;
	localparam int PhaseCycles  = SettleCycles + (40 + 5 * MaxPeriod) * `MB_SAMPLE_DIV;
	localparam longint WatchdogNs = longint'(NumPhases + 2) * PhaseCycles * 10 + 100000;

	logic                 clock50Mhz = 1'b0;
	logic                 arstN;
	musicBoxPkg::keyMaskT musicKeysN;
	logic                 beeModeN;
	musicBoxPkg::levelT   volume;
	logic                 spiSclk;
	logic                 spiSyncN;
	logic                 spiDin;
	logic                 beeModeLed;

	musicBoxPkg::spiWordT frames[$]; // Captured words, oldest first
	int                   frameCount = 0;
	logic                 beeExp = 1'b0; // Expected bee mode

	musicBoxTop dut_i (
		.clock50Mhz (clock50Mhz),
		.arstN      (arstN),
		.musicKeysN (musicKeysN),
		.beeModeN   (beeModeN),
		.volume     (volume),
		.spiSclk    (spiSclk),
		.spiSyncN   (spiSyncN),
		.spiDin     (spiDin),
		.beeModeLed (beeModeLed)
	);

	always #5 clock50Mhz = !clock50Mhz; // 10 ns period

	// ----------------------------------------
	// Failure and compare tasks
	// ----------------------------------------
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input musicBoxPkg::spiWordT got,
			input musicBoxPkg::spiWordT exp);
		if (got !== exp)
			failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic checkLed(input string name, input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic int periodOfKey(input int idx);
		case (idx)
			0:       return `MB_KEY_PERIOD0;
			1:       return `MB_KEY_PERIOD1;
			2:       return `MB_KEY_PERIOD2;
			3:       return `MB_KEY_PERIOD3;
			4:       return `MB_KEY_PERIOD4;
			default: return `MB_KEY_PERIOD5;
		endcase
	endfunction

	function automatic int periodOfMask(input musicBoxPkg::keyMaskT mask);
		for (int i = 0; i < 6; i++)
			if (mask[i])
				return periodOfKey(i); // Lowest pressed key wins
		return 0;
	endfunction

	// Half-up rounding of raw * vol / 255
	function automatic int scaleModel(input int raw, input int vol);
		return (2 * raw * vol + 255) / 510;
	endfunction

	function automatic musicBoxPkg::spiWordT toneWord(input int ph, input int period,
			input logic bee, input int vol);
		int raw;
		if (bee)
			raw = ph * (255 / (period - 1)); // Sawtooth
		else
			raw = (ph < period / 2) ? 255 : 0; // Square
		return musicBoxPkg::spiWordT'(scaleModel(raw, vol) * 16);
	endfunction

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------
	task automatic waitCycles(input int n);
		repeat (n) @(posedge clock50Mhz);
		#1; // Drive point after the edge
	endtask

	task automatic getFrame(output musicBoxPkg::spiWordT w);
		int waited;
		waited = 0;
		while (frames.size() == 0) begin
			@(posedge clock50Mhz);
			waited++;
			if (waited > 2 * `MB_SAMPLE_DIV)
				failRun("no SPI frame arrived within two sample periods");
		end
		w = frames.pop_front();
	endtask

	// Button low for lowCycles, then released long enough to settle
	task automatic pulseBee(input int lowCycles);
		beeModeN = 1'b0;
		waitCycles(lowCycles);
		beeModeN = 1'b1;
		waitCycles(`MB_DEBOUNCE_CYCLES + 8);
	endtask

	task automatic checkSilence(input int n);
		musicBoxPkg::spiWordT w;
		frames.delete();
		repeat (n) begin
			getFrame(w);
			checkWord("spi frame", w, '0);
		end
	endtask

	// Align on phase 0, then compare three full periods
	task automatic checkTone(input int period, input logic bee, input int vol);
		musicBoxPkg::spiWordT prev;
		musicBoxPkg::spiWordT cur;
		bit                   found;
		found = 0;
		frames.delete();
		getFrame(prev);
		cur = prev;
		if (bee && prev == '0)
			found = 1; // Already on the zero sample
		for (int i = 0; i < 2 * period + 2 && !found; i++) begin
			getFrame(cur);
			if (bee)
				found = (cur == '0);
			else
				found = (prev == '0 && cur != '0); // First high sample
			prev = cur;
		end
		if (!found)
			failRun($sformatf("no tone start found for period %0d", period));
		for (int p = 0; p < 3 * period; p++) begin
			if (p != 0)
				getFrame(cur);
			checkWord("spi frame", cur, toneWord(p % period, period, bee, vol));
		end
		waitCycles(1); // Back to the drive point
	endtask

	// ----------------------------------------
	// SPI frame capture
	// ----------------------------------------
	always begin : frameCapture
		musicBoxPkg::spiWordT word;
		int                   bits;
		@(negedge spiSyncN);
		word = '0;
		bits = 0;
		while (spiSyncN === 1'b0) begin
			@(negedge spiSclk or posedge spiSyncN);
			if (spiSyncN === 1'b0) begin
				word = {word[14:0], spiDin}; // MSB first
				bits++;
			end
		end
		if (bits != 16)
			failRun($sformatf("SPI frame had %0d SCLK pulses instead of 16", bits));
		if (word[15:12] != 4'h0)
			failRun($sformatf("SPI frame 0x%h has non-zero control bits", word));
		frames.push_back(word);
		frameCount++;
	end

	// Watchdog
	initial begin
		#(WatchdogNs);
		failRun("watchdog expired before the test sequence finished");
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin : mainSeq
		musicBoxPkg::keyMaskT mask;
		int                   vol;
		int                   startCount;
		int                   nFrames;
		logic                 doPress;
		void'($urandom(32'h48652b53)); // Seeds the generator once
		arstN      = 1'b0;
		musicKeysN = '1; // All released
		beeModeN   = 1'b1;
		volume     = 8'd128;
		waitCycles(10);
		arstN = 1'b1;
		waitCycles(1);
		checkLed("spiSyncN", spiSyncN, 1'b1);
		checkLed("spiSclk", spiSclk, 1'b0);
		checkLed("spiDin", spiDin, 1'b0);
		checkLed("beeModeLed", beeModeLed, 1'b0);

		// Silence and frame cadence
		checkSilence(10);
		startCount = frameCount;
		waitCycles(20 * `MB_SAMPLE_DIV);
		nFrames = frameCount - startCount;
		if (nFrames < 19 || nFrames > 21)
			failRun($sformatf("%0d frames in 20 sample periods", nFrames));

		for (int ph = 0; ph < NumPhases; ph++) begin
			mask       = musicBoxPkg::keyMaskT'($urandom_range(1, 63));
			vol        = $urandom_range(128, 255);
			musicKeysN = ~mask;
			volume     = musicBoxPkg::levelT'(vol);
			pulseBee($urandom_range(1, `MB_DEBOUNCE_CYCLES - 1)); // Bounce only
			checkLed("beeModeLed", beeModeLed, beeExp);
			doPress = (ph % 2 == 1) ? 1'b1 : logic'($urandom_range(0, 1));
			if (doPress) begin
				pulseBee(`MB_DEBOUNCE_CYCLES + 8);
				beeExp = !beeExp;
				checkLed("beeModeLed", beeModeLed, beeExp);
			end
			waitCycles(SettleCycles);
			checkTone(periodOfMask(mask), beeExp, vol);
		end

		musicKeysN = '1;
		waitCycles(SettleCycles);
		checkSilence(5);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
